/* include/board_shell_macros.svh */
`ifndef BOARD_SHELL_MACROS_SVH
`define BOARD_SHELL_MACROS_SVH

// host bus geometry
`define BOARD_ADDR_W 32        // full host byte address
`define BOARD_DATA_W 32        // wishbone data width
`define BOARD_SEL_W  4         // one select per data byte

// address map, region field of the host address
`define REGION_MMIO    0       // scratch window standing in for the core mmio port
`define REGION_CLKCTRL 1       // clock generator control block

`define MMIO_WORDS 16          // scratch words, counter sits at this index

// reset sequencing
`define SYNC_STAGES       4    // flops on the asynchronous lock input
`define RESET_HOLD_CYCLES 16   // release cycles before core reset drops

`endif

/* source/board_bus_pkg.sv */
`include "board_shell_macros.svh"

package board_bus_pkg;

  // field view of a host address, msb first
  typedef struct packed {
    logic [13:0] rsvd;         // above the decoded map
    logic [3:0]  region;       // picks the target
    logic [11:0] word_idx;     // word inside the target
    logic [1:0]  byte_off;     // byte lane, targets work on words
  } host_addr_fields_t;

  // decoder reads the region, targets read the word index
  typedef union packed {
    logic [`BOARD_ADDR_W-1:0] raw;
    host_addr_fields_t        f;
  } host_addr_u;

  // wishbone classic request, master to slave
  typedef struct packed {
    logic                     cyc;    // bus cycle in progress
    logic                     stb;    // this target is strobed
    logic                     we;     // 1 write, 0 read
    host_addr_u               addr;
    logic [`BOARD_SEL_W-1:0]  sel;    // byte enables for writes
    logic [`BOARD_DATA_W-1:0] wdata;
  } wb_req_t;

  // wishbone classic response, slave to master
  typedef struct packed {
    logic                     ack;    // single cycle pulse
    logic [`BOARD_DATA_W-1:0] rdata;  // valid while ack is high
  } wb_rsp_t;

endpackage

/* source/board_ctrl_pkg.sv */
`include "board_shell_macros.svh"

package board_ctrl_pkg;

  // CTRL register, read-write on the two low bits
  typedef struct packed {
    logic [`BOARD_DATA_W-3:0] rsvd;          // always read 0
    logic                     core_run;      // host allows the core to leave reset
    logic                     clkgen_reset;  // held high out of reset
  } clk_ctrl_t;

  // STATUS register, read only
  typedef struct packed {
    logic [`BOARD_DATA_W-3:0] rsvd;          // always read 0
    logic                     core_reset;    // sequencer output as seen now
    logic                     locked_sync;   // lock after the synchroniser
  } clk_status_t;

  // word indices inside the clock-control region
  localparam logic [11:0] CTRL_IDX   = 12'd0;
  localparam logic [11:0] STATUS_IDX = 12'd1;

endpackage

/* source/host_addr_decode.sv */
`timescale 1ns/1ps
`include "board_shell_macros.svh"

module host_addr_decode (
  input  logic                  clk_wiz_refclk,
  input  logic                  reset,
  input  board_bus_pkg::wb_req_t host_req,
  output board_bus_pkg::wb_rsp_t host_rsp,
  output board_bus_pkg::wb_req_t mmio_req,
  input  board_bus_pkg::wb_rsp_t mmio_rsp,
  output board_bus_pkg::wb_req_t clk_req,
  input  board_bus_pkg::wb_rsp_t clk_rsp
);

  import board_bus_pkg::*;

  host_addr_u addr;          // region view of the host address
  logic       hit_mmio;
  logic       hit_clk;
  logic       unmapped_ack;  // local responder for holes in the map

  assign addr     = host_req.addr;
  assign hit_mmio = (addr.f.region == 4'(`REGION_MMIO));
  assign hit_clk  = (addr.f.region == 4'(`REGION_CLKCTRL));

  // both targets see the whole request, only the matching one gets stb
  always_comb begin
    mmio_req     = host_req;
    mmio_req.stb = host_req.stb & hit_mmio;
    clk_req      = host_req;
    clk_req.stb  = host_req.stb & hit_clk;
  end

  // unmapped region acks one cycle later like a real target, writes dropped
  always_ff @(posedge clk_wiz_refclk) begin
    if (reset) begin
      unmapped_ack <= 1'b0;
    end else begin
      unmapped_ack <= host_req.cyc & host_req.stb & ~hit_mmio & ~hit_clk
                      & ~unmapped_ack;  // no back-to-back ack
    end
  end

  // only one source can ack in a given cycle
  always_comb begin
    host_rsp.ack = mmio_rsp.ack | clk_rsp.ack | unmapped_ack;
    if (mmio_rsp.ack) begin
      host_rsp.rdata = mmio_rsp.rdata;
    end else if (clk_rsp.ack) begin
      host_rsp.rdata = clk_rsp.rdata;
    end else begin
      host_rsp.rdata = '0;  // unmapped reads and idle bus
    end
  end

endmodule

/* source/mmio_regfile.sv */
`timescale 1ns/1ps
`include "board_shell_macros.svh"

module mmio_regfile (
  input  logic                   clk_wiz_refclk,
  input  logic                   reset,
  input  board_bus_pkg::wb_req_t req,
  output board_bus_pkg::wb_rsp_t rsp
);

  import board_bus_pkg::*;

  localparam int          IDX_W   = $clog2(`MMIO_WORDS);  // bits that pick a scratch word
  localparam logic [11:0] CNT_IDX = 12'(`MMIO_WORDS);     // counter just past the array

  host_addr_u               addr;
  logic                     acc;       // cycle accepted on this edge
  logic                     in_array;  // index hits a scratch word
  logic                     ack_q;
  logic [`BOARD_DATA_W-1:0] rdata_q;
  logic [`BOARD_DATA_W-1:0] rd_word;
  logic [`BOARD_DATA_W-1:0] wr_count;  // acknowledged writes, like the core push counter
  logic [`BOARD_DATA_W-1:0] mem [`MMIO_WORDS];

  assign addr     = req.addr;
  assign acc      = req.cyc & req.stb & ~ack_q;  // skip the cycle that already acks
  assign in_array = (addr.f.word_idx < CNT_IDX);

  // read mux, counter is read only, the rest of the region reads zero
  always_comb begin
    if (in_array) begin
      rd_word = mem[addr.f.word_idx[IDX_W-1:0]];
    end else if (addr.f.word_idx == CNT_IDX) begin
      rd_word = wr_count;
    end else begin
      rd_word = '0;
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (reset) begin
      ack_q    <= 1'b0;
      wr_count <= '0;
      for (int i = 0; i < `MMIO_WORDS; i++) begin
        mem[i] <= '0;  // scratch comes up clean
      end
    end else begin
      ack_q <= acc;
      if (acc && req.we) begin
        wr_count <= wr_count + 1'b1;  // every acked write counts, ignored ones too
        if (in_array) begin
          for (int b = 0; b < `BOARD_SEL_W; b++) begin
            if (req.sel[b]) begin
              mem[addr.f.word_idx[IDX_W-1:0]][b*8 +: 8] <= req.wdata[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  // read data captured with the ack, old value on a write cycle
  always_ff @(posedge clk_wiz_refclk) begin
    if (acc) begin
      rdata_q <= rd_word;
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;

endmodule

/* source/clock_ctrl_regs.sv */
`timescale 1ns/1ps

module clock_ctrl_regs (
  input  logic                    clk_wiz_refclk,
  input  logic                    reset,
  input  board_bus_pkg::wb_req_t  req,
  output board_bus_pkg::wb_rsp_t  rsp,
  input  logic                    locked_sync,
  input  logic                    core_reset,
  output board_ctrl_pkg::clk_ctrl_t ctrl
);

  import board_bus_pkg::*;
  import board_ctrl_pkg::*;

  host_addr_u  addr;
  logic        acc;       // request taken on this edge
  logic        ack_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_word;
  clk_ctrl_t   ctrl_q;
  clk_ctrl_t   wr_ctrl;   // write data seen as CTRL fields
  clk_status_t status;

  assign addr    = req.addr;
  assign acc     = req.cyc & req.stb & ~ack_q;
  assign wr_ctrl = clk_ctrl_t'(req.wdata);

  // status is live, nothing stored here
  always_comb begin
    status             = '0;
    status.locked_sync = locked_sync;
    status.core_reset  = core_reset;
  end

  always_comb begin
    case (addr.f.word_idx)
      CTRL_IDX:   rd_word = ctrl_q;
      STATUS_IDX: rd_word = status;
      default:    rd_word = '0;  // rest of the region is empty
    endcase
  end

  // clock generator starts in reset and the core is not allowed to run
  always_ff @(posedge clk_wiz_refclk) begin
    if (reset) begin
      ack_q               <= 1'b0;
      ctrl_q              <= '0;
      ctrl_q.clkgen_reset <= 1'b1;
    end else begin
      ack_q <= acc;
      if (acc && req.we && addr.f.word_idx == CTRL_IDX) begin
        ctrl_q.clkgen_reset <= wr_ctrl.clkgen_reset;  // whole word, sel not used
        ctrl_q.core_run     <= wr_ctrl.core_run;      // reserved bits stay zero
      end
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (acc) begin
      rdata_q <= rd_word;  // held for the ack cycle
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;
  assign ctrl      = ctrl_q;

endmodule

/* source/reset_sequencer.sv */
`timescale 1ns/1ps
`include "board_shell_macros.svh"

module reset_sequencer (
  input  logic                      clk_wiz_refclk,
  input  logic                      reset,
  input  logic                      clk_locked,
  input  board_ctrl_pkg::clk_ctrl_t ctrl,
  output logic                      locked_sync,
  output logic                      core_reset
);

  localparam int             CNT_W = $clog2(`RESET_HOLD_CYCLES + 1);
  localparam logic [CNT_W-1:0] HOLD = CNT_W'(`RESET_HOLD_CYCLES);

  logic [`SYNC_STAGES-1:0] lock_sync_q;   // lock comes from another clock, shift it in
  logic                    release_ok;    // every release condition met this cycle
  logic [CNT_W-1:0]        hold_cnt;
  logic [CNT_W-1:0]        cnt_next;
  logic                    core_reset_q;

  // chain of flops, the oldest bit is the clean lock
  always_ff @(posedge clk_wiz_refclk) begin
    if (reset) begin
      lock_sync_q <= '0;
    end else begin
      lock_sync_q <= {lock_sync_q[`SYNC_STAGES-2:0], clk_locked};
    end
  end

  assign locked_sync = lock_sync_q[`SYNC_STAGES-1];

  // generator out of reset, host asked to run, clock is locked
  assign release_ok = ctrl.core_run & ~ctrl.clkgen_reset & locked_sync;

  assign cnt_next = (hold_cnt == HOLD) ? hold_cnt : hold_cnt + 1'b1;  // saturate

  // any dropped condition restarts the hold and reasserts reset next edge
  always_ff @(posedge clk_wiz_refclk) begin
    if (reset || !release_ok) begin
      hold_cnt     <= '0;
      core_reset_q <= 1'b1;
    end else begin
      hold_cnt     <= cnt_next;
      core_reset_q <= (cnt_next != HOLD);  // falls as the count reaches the hold
    end
  end

  assign core_reset = core_reset_q;

endmodule

/* source/board_shell_top.sv */
`timescale 1ns/1ps

module board_shell_top (
  input  logic                   clk_wiz_refclk,
  input  logic                   reset,
  input  board_bus_pkg::wb_req_t host_req,
  output board_bus_pkg::wb_rsp_t host_rsp,
  input  logic                   clk_locked,
  output logic                   clkgen_reset,
  output logic                   core_reset
);

  import board_bus_pkg::*;
  import board_ctrl_pkg::*;

  wb_req_t   mmio_req;     // decoder to scratch window
  wb_rsp_t   mmio_rsp;
  wb_req_t   clk_req;      // decoder to clock control
  wb_rsp_t   clk_rsp;
  clk_ctrl_t ctrl;         // CTRL register contents
  logic      locked_sync;  // lock after the synchroniser
  logic      core_reset_w; // sequencer output, also read back in STATUS

  host_addr_decode u_decode (
    .clk_wiz_refclk (clk_wiz_refclk),
    .reset          (reset),
    .host_req       (host_req),
    .host_rsp       (host_rsp),
    .mmio_req       (mmio_req),
    .mmio_rsp       (mmio_rsp),
    .clk_req        (clk_req),
    .clk_rsp        (clk_rsp)
  );

  mmio_regfile u_mmio (
    .clk_wiz_refclk (clk_wiz_refclk),
    .reset          (reset),
    .req            (mmio_req),
    .rsp            (mmio_rsp)
  );

  clock_ctrl_regs u_clk_regs (
    .clk_wiz_refclk (clk_wiz_refclk),
    .reset          (reset),
    .req            (clk_req),
    .rsp            (clk_rsp),
    .locked_sync    (locked_sync),
    .core_reset     (core_reset_w),
    .ctrl           (ctrl)
  );

  reset_sequencer u_rst_seq (
    .clk_wiz_refclk (clk_wiz_refclk),
    .reset          (reset),
    .clk_locked     (clk_locked),
    .ctrl           (ctrl),
    .locked_sync    (locked_sync),
    .core_reset     (core_reset_w)
  );

  assign clkgen_reset = ctrl.clkgen_reset;  // straight to the clock generator
  assign core_reset   = core_reset_w;

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 20,  // 40 ns clock
  parameter int RESET_CYCLES   = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // reset spans the first rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

/* dv/board_shell_tb.sv */
`timescale 1ns/1ps
`include "board_shell_macros.svh"

module board_shell_tb;

  import board_bus_pkg::*;
  import board_ctrl_pkg::*;

  localparam int ACK_TIMEOUT  = 20;   // cycles allowed for one bus ack
  localparam int WAIT_TIMEOUT = 200;  // cycles allowed for reset and lock waits

  logic    clk_wiz_refclk;
  logic    reset;
  wb_req_t host_req;
  wb_rsp_t host_rsp;
  logic    clk_locked;
  logic    clkgen_reset;
  logic    core_reset;

  logic [31:0] model_mem [`MMIO_WORDS];  // expected scratch contents
  logic [31:0] model_count;              // expected accepted-write count
  logic [31:0] model_ctrl;               // expected CTRL word
  logic        exp_locked;               // expected STATUS bit 0
  logic        exp_core_reset;           // expected STATUS bit 1

  string       cmp_name;     // handoff from the read task to the compare process
  logic [31:0] cmp_expect;
  logic [31:0] cmp_actual;
  logic        cmp_pending;

  int     err_count;
  int     tests_passed;
  int     tests_failed;
  logic   timed_out;  // set once any wait gives up, later bus work is skipped
  integer seed;

  tb_clock_gen u_clk_gen (
    .clk   (clk_wiz_refclk),
    .reset (reset)
  );

  board_shell_top UUT (
    .clk_wiz_refclk (clk_wiz_refclk),
    .reset          (reset),
    .host_req       (host_req),
    .host_rsp       (host_rsp),
    .clk_locked     (clk_locked),
    .clkgen_reset   (clkgen_reset),
    .core_reset     (core_reset)
  );

  function automatic logic [31:0] make_addr(input logic [3:0] region, input logic [11:0] idx);
    host_addr_u a;
    a.raw        = '0;
    a.f.region   = region;
    a.f.word_idx = idx;
    return a.raw;
  endfunction

  // expected read data from the address map and the model state
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    host_addr_u a;
    a.raw = addr;
    if (a.f.region == 4'(`REGION_MMIO)) begin
      if (a.f.word_idx < 12'(`MMIO_WORDS)) return model_mem[a.f.word_idx[3:0]];
      if (a.f.word_idx == 12'(`MMIO_WORDS)) return model_count;  // counter word
      return '0;
    end
    if (a.f.region == 4'(`REGION_CLKCTRL)) begin
      if (a.f.word_idx == CTRL_IDX) return model_ctrl;
      if (a.f.word_idx == STATUS_IDX) return {30'd0, exp_core_reset, exp_locked};
      return '0;
    end
    return '0;  // holes in the map read zero
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [3:0] sel,
                                      input logic [31:0] data);
    host_addr_u a;
    a.raw = addr;
    if (a.f.region == 4'(`REGION_MMIO)) begin
      model_count = model_count + 32'd1;  // any write in the window counts
      if (a.f.word_idx < 12'(`MMIO_WORDS)) begin
        for (int b = 0; b < `BOARD_SEL_W; b++) begin
          if (sel[b]) model_mem[a.f.word_idx[3:0]][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end else if (a.f.region == 4'(`REGION_CLKCTRL) && a.f.word_idx == CTRL_IDX) begin
      model_ctrl = data & 32'h3;  // only the two control bits hold
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  // one classic cycle, called on a falling edge, returns on the ack's falling edge
  task automatic bus_cycle(input logic we, input logic [31:0] addr, input logic [3:0] sel,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    host_req.cyc      = 1'b1;
    host_req.stb      = 1'b1;
    host_req.we       = we;
    host_req.addr.raw = addr;
    host_req.sel      = sel;
    host_req.wdata    = wdata;
    do begin
      @(negedge clk_wiz_refclk);
      waited++;
    end while (!host_rsp.ack && waited < ACK_TIMEOUT);
    if (host_rsp.ack) begin
      rdata = host_rsp.rdata;
    end else begin
      $display("timeout: no ack within %0d cycles for address %h", ACK_TIMEOUT, addr);
      timed_out = 1'b1;
    end
    host_req = '0;  // stb drops for the idle cycle
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [3:0] sel,
                            input logic [31:0] data);
    logic [31:0] rd_ignored;
    if (!timed_out) begin
      bus_cycle(1'b1, addr, sel, data, rd_ignored);
      if (!timed_out) model_write(addr, sel, data);
      @(negedge clk_wiz_refclk);  // idle cycle
    end
  endtask

  task automatic read_check(input string name, input logic [31:0] addr);
    logic [31:0] data;
    logic [31:0] expected;
    if (!timed_out) begin
      expected = expected_read(addr);
      bus_cycle(1'b0, addr, 4'hf, 32'd0, data);
      if (!timed_out) begin
        cmp_name    = name;
        cmp_expect  = expected;
        cmp_actual  = data;
        cmp_pending = 1'b1;
      end
      @(negedge clk_wiz_refclk);  // compare process runs on the edge in here
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before && !timed_out) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed", name);
    end
  endtask

  always @(posedge clk_wiz_refclk) begin
    if (cmp_pending) begin
      check_value(cmp_name, cmp_expect, cmp_actual);
      cmp_pending = 1'b0;
    end
  end

  initial begin
    int          errs;
    int          cycles;
    logic [31:0] data;
    logic [31:0] rnd;
    host_req       = '0;
    clk_locked     = 1'b0;
    cmp_pending    = 1'b0;
    err_count      = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;
    seed           = 32'hcd61;
    model_count    = '0;
    model_ctrl     = 32'h1;  // clkgen_reset comes up set
    exp_locked     = 1'b0;
    exp_core_reset = 1'b1;
    for (int i = 0; i < `MMIO_WORDS; i++) model_mem[i] = '0;

    cycles = 0;
    do begin
      @(negedge clk_wiz_refclk);
      cycles++;
    end while (reset && cycles < WAIT_TIMEOUT);
    if (reset) begin
      $display("timeout: reset never released");
      timed_out = 1'b1;
    end

    errs = err_count;
    for (int i = 0; i < `MMIO_WORDS; i++) begin
      data = $random(seed);
      rnd  = $random(seed);
      write_word(make_addr(4'(`REGION_MMIO), 12'(i)), rnd[3:0], data);  // random lanes
    end
    for (int i = 0; i < `MMIO_WORDS; i++) begin
      read_check($sformatf("scratch_%0d", i), make_addr(4'(`REGION_MMIO), 12'(i)));
    end
    finish_test("mmio_scratch", errs);

    errs = err_count;
    write_word(make_addr(4'(`REGION_MMIO), 12'd20), 4'hf, 32'h1234_5678);  // ignored index
    write_word(make_addr(4'(`REGION_MMIO), 12'd100), 4'h3, 32'h0bad_f00d);
    read_check("write_count", make_addr(4'(`REGION_MMIO), 12'(`MMIO_WORDS)));
    write_word(make_addr(4'(`REGION_MMIO), 12'(`MMIO_WORDS)), 4'hf, 32'hdead_beef);
    read_check("count_after_write", make_addr(4'(`REGION_MMIO), 12'(`MMIO_WORDS)));
    finish_test("write_counter", errs);

    errs = err_count;
    check_value("ack_idle_after_reset", 32'd0, {31'd0, host_rsp.ack});
    check_value("clkgen_reset_default", 32'd1, {31'd0, clkgen_reset});
    check_value("core_reset_default", 32'd1, {31'd0, core_reset});
    read_check("ctrl_default", make_addr(4'(`REGION_CLKCTRL), CTRL_IDX));
    write_word(make_addr(4'(`REGION_CLKCTRL), CTRL_IDX), 4'hf, 32'h2);  // run, generator live
    read_check("ctrl_run", make_addr(4'(`REGION_CLKCTRL), CTRL_IDX));
    check_value("clkgen_reset_cleared", 32'd0, {31'd0, clkgen_reset});
    write_word(make_addr(4'(`REGION_CLKCTRL), CTRL_IDX), 4'h0, 32'hffff_fffe);
    read_check("ctrl_reserved", make_addr(4'(`REGION_CLKCTRL), CTRL_IDX));
    finish_test("ctrl_regs", errs);

    errs = err_count;
    check_value("core_reset_unlocked", 32'd1, {31'd0, core_reset});
    read_check("status_unlocked", make_addr(4'(`REGION_CLKCTRL), STATUS_IDX));
    clk_locked = 1'b1;  // raised on a falling edge
    cycles = 0;
    while (core_reset && cycles < WAIT_TIMEOUT && !timed_out) begin
      @(negedge clk_wiz_refclk);
      cycles++;
    end
    if (core_reset) begin
      $display("timeout: core_reset still high %0d cycles after lock", cycles);
      timed_out = 1'b1;
    end else if (cycles < `RESET_HOLD_CYCLES) begin
      $display("core_reset released after %0d cycles, hold is %0d cycles",
               cycles, `RESET_HOLD_CYCLES);
      err_count++;
    end
    exp_locked     = 1'b1;
    exp_core_reset = 1'b0;
    read_check("status_running", make_addr(4'(`REGION_CLKCTRL), STATUS_IDX));
    write_word(make_addr(4'(`REGION_CLKCTRL), CTRL_IDX), 4'hf, 32'h0);  // stop the core
    check_value("core_reset_on_stop", 32'd1, {31'd0, core_reset});       // two cycles past ack
    exp_core_reset = 1'b1;
    read_check("status_stopped", make_addr(4'(`REGION_CLKCTRL), STATUS_IDX));
    finish_test("reset_sequencing", errs);

    errs = err_count;
    read_check("unmapped_read", make_addr(4'd5, 12'd0));
    write_word(make_addr(4'd5, 12'd0), 4'hf, 32'hffff_ffff);  // must land nowhere
    read_check("unmapped_scratch_0", make_addr(4'(`REGION_MMIO), 12'd0));
    read_check("unmapped_count", make_addr(4'(`REGION_MMIO), 12'(`MMIO_WORDS)));
    read_check("unmapped_ctrl", make_addr(4'(`REGION_CLKCTRL), CTRL_IDX));
    finish_test("unmapped_region", errs);

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (err_count == 0 && tests_failed == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
source/board_bus_pkg.sv
source/board_ctrl_pkg.sv
source/host_addr_decode.sv
source/mmio_regfile.sv
source/clock_ctrl_regs.sv
source/reset_sequencer.sv
source/board_shell_top.sv
dv/tb_clock_gen.sv
dv/board_shell_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the board shell testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

# a build or run error is written to the log as a failure
verilator --binary --timing -f build.f --top-module board_shell_tb \
    -o board_shell_sim > "$LOG" 2>&1 \
  && ./obj_dir/board_shell_sim >> "$LOG" 2>&1 \
  || echo "TEST FAIL" >> "$LOG"

cat "$LOG"
grep -q "TEST FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
